//--- common/exe_pkg.sv
package exe_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_t;

    typedef enum logic [3:0] {
        mem_none  = 4'd0,
        mem_ld_b  = 4'd1,
        mem_ld_bu = 4'd2,
        mem_ld_h  = 4'd3,
        mem_ld_hu = 4'd4,
        mem_ld_w  = 4'd5,
        mem_st_b  = 4'd6,
        mem_st_h  = 4'd7,
        mem_st_w  = 4'd8
    } mem_op_t;

    // loongarch ecode numbering
    typedef enum logic [5:0] {
        ecode_none = 6'h00,
        ecode_pil  = 6'h01,   // load, page invalid
        ecode_pis  = 6'h02,   // store, page invalid
        ecode_pme  = 6'h04,   // page modify
        ecode_ppi  = 6'h07,   // privilege violation
        ecode_ade  = 6'h08,
        ecode_ale  = 6'h09,
        ecode_tlbr = 6'h3f    // refill
    } ecode_t;

endpackage

//--- common/mmu_pkg.sv
package mmu_pkg;

    typedef logic [1:0] plv_t;

    // page size codes, log2 of the page
    localparam logic [5:0] PS_4K = 6'd12;
    localparam logic [5:0] PS_4M = 6'd22;

    // crmd fields
    localparam int CRMD_PLV_LO = 0;
    localparam int CRMD_DA     = 3;
    localparam int CRMD_PG     = 4;

    typedef struct packed {
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic        g;      // global, ignores asid
        logic [9:0]  asid;
        logic [19:0] ppn;
        plv_t        plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
        logic        e;      // entry exists
    } tlb_entry_t;

endpackage

//--- common/tlb_search_if.sv
`timescale 1ns/1ps

interface tlb_search_if #(
    parameter int tlb_entries = 16
);
    logic [19:0]                    va_high;
    logic [9:0]                     asid;
    logic                           found;
    logic [$clog2(tlb_entries)-1:0] index;
    logic [19:0]                    ppn;
    logic [5:0]                     ps;
    mmu_pkg::plv_t                  plv;
    logic [1:0]                     mat;
    logic                           d;
    logic                           v;

    // combinational lookup, answer comes back in the same cycle
    modport exe (output va_high, asid, input found, index, ppn, ps, plv, mat, d, v);
    modport tlb (input va_high, asid, output found, index, ppn, ps, plv, mat, d, v);

endinterface

//--- exe/alu.sv
`timescale 1ns/1ps

module alu (
    input  exe_pkg::alu_op_t          op,
    input  logic [exe_pkg::XLEN-1:0]  src1,
    input  logic [exe_pkg::XLEN-1:0]  src2,
    output logic [exe_pkg::XLEN-1:0]  result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            exe_pkg::alu_add:  result = src1 + src2;
            exe_pkg::alu_sub:  result = src1 - src2;
            exe_pkg::alu_slt:  result = {{(exe_pkg::XLEN-1){1'b0}}, lt_signed};
            exe_pkg::alu_sltu: result = {{(exe_pkg::XLEN-1){1'b0}}, lt_unsigned};
            exe_pkg::alu_and:  result = src1 & src2;
            exe_pkg::alu_or:   result = src1 | src2;
            exe_pkg::alu_xor:  result = src1 ^ src2;
            exe_pkg::alu_nor:  result = ~(src1 | src2);
            exe_pkg::alu_sll:  result = src1 << shamt;
            exe_pkg::alu_srl:  result = src1 >> shamt;
            exe_pkg::alu_sra:  result = $unsigned($signed(src1) >>> shamt);
            exe_pkg::alu_lui:  result = src2;   // decode already placed imm in 31:12
            default:           result = '0;
        endcase
    end

endmodule

//--- exe/mem_request.sv
`timescale 1ns/1ps

module mem_request (
    input  exe_pkg::mem_op_t          mem_op,
    input  logic [exe_pkg::XLEN-1:0]  addr,
    input  logic [exe_pkg::XLEN-1:0]  store_data,
    output logic                      is_load,
    output logic                      is_store,
    output logic                      misaligned,
    output logic [1:0]                size,
    output logic [3:0]                strobe,
    output logic [exe_pkg::XLEN-1:0]  wdata
);

    logic [3:0] byte_sel;

    assign byte_sel = 4'b0001 << addr[1:0];

    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        misaligned = 1'b0;
        size       = 2'd2;
        strobe     = 4'b0000;   // loads never write
        wdata      = store_data;
        case (mem_op)
            exe_pkg::mem_ld_b, exe_pkg::mem_ld_bu: begin
                is_load = 1'b1;
                size    = 2'd0;
            end
            exe_pkg::mem_ld_h, exe_pkg::mem_ld_hu: begin
                is_load    = 1'b1;
                size       = 2'd1;
                misaligned = addr[0];
            end
            exe_pkg::mem_ld_w: begin
                is_load    = 1'b1;
                misaligned = |addr[1:0];
            end
            exe_pkg::mem_st_b: begin
                is_store = 1'b1;
                size     = 2'd0;
                strobe   = byte_sel;
                wdata    = {4{store_data[7:0]}};
            end
            exe_pkg::mem_st_h: begin
                is_store   = 1'b1;
                size       = 2'd1;
                misaligned = addr[0];
                strobe     = addr[1] ? 4'b1100 : 4'b0011;
                wdata      = {2{store_data[15:0]}};
            end
            exe_pkg::mem_st_w: begin
                is_store   = 1'b1;
                misaligned = |addr[1:0];
                strobe     = 4'b1111;
            end
            default: ;
        endcase
    end

endmodule

//--- exe/addr_translate.sv
`timescale 1ns/1ps

module addr_translate (
    input  logic [exe_pkg::XLEN-1:0]  vaddr,
    input  logic                      is_load,
    input  logic                      is_store,
    input  logic [31:0]               csr_crmd,
    input  logic [31:0]               csr_asid,
    input  logic [31:0]               csr_dmw0,
    input  logic [31:0]               csr_dmw1,
    tlb_search_if.exe                 srch,
    output logic [exe_pkg::XLEN-1:0]  paddr,
    output exe_pkg::ecode_t           fault,
    output logic                      ade
);

    logic          mem;
    mmu_pkg::plv_t plv;
    logic          direct;
    logic          dmw_hit0;
    logic          dmw_hit1;
    logic          tlb_trans;
    logic [31:0]   tlb_paddr;

    assign mem    = is_load | is_store;
    assign plv    = mmu_pkg::plv_t'(csr_crmd[mmu_pkg::CRMD_PLV_LO +: 2]);
    assign direct = csr_crmd[mmu_pkg::CRMD_DA] & ~csr_crmd[mmu_pkg::CRMD_PG];

    // plv enable bits sit at dmw[3:0], one per level
    assign dmw_hit0 = csr_dmw0[plv] && (csr_dmw0[31:29] == vaddr[31:29]);
    assign dmw_hit1 = csr_dmw1[plv] && (csr_dmw1[31:29] == vaddr[31:29]);

    assign srch.va_high = vaddr[31:12];
    assign srch.asid    = csr_asid[9:0];

    assign tlb_paddr = (srch.ps == mmu_pkg::PS_4K) ? {srch.ppn, vaddr[11:0]}
                                                   : {srch.ppn[19:10], vaddr[21:0]};

    assign paddr = direct   ? vaddr
                 : dmw_hit0 ? {csr_dmw0[27:25], vaddr[28:0]}   // window 0 wins
                 : dmw_hit1 ? {csr_dmw1[27:25], vaddr[28:0]}
                 : tlb_paddr;

    assign tlb_trans = mem & ~direct & ~dmw_hit0 & ~dmw_hit1;

    // upper half is off limits to user level unless a window covers it
    assign ade = tlb_trans & vaddr[31] & (plv == 2'd3);

    always_comb begin
        fault = exe_pkg::ecode_none;
        if (tlb_trans) begin
            if (!srch.found)
                fault = exe_pkg::ecode_tlbr;
            else if (is_load && !srch.v)
                fault = exe_pkg::ecode_pil;
            else if (is_store && !srch.v)
                fault = exe_pkg::ecode_pis;
            else if (plv > srch.plv)
                fault = exe_pkg::ecode_ppi;
            else if (is_store && !srch.d)
                fault = exe_pkg::ecode_pme;
        end
    end

endmodule

//--- exe/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             in_valid,
    output logic                             in_allowin,
    input  logic [exe_pkg::XLEN-1:0]         in_pc,
    input  exe_pkg::alu_op_t                 in_alu_op,
    input  logic [exe_pkg::XLEN-1:0]         in_src1,
    input  logic [exe_pkg::XLEN-1:0]         in_src2,
    input  exe_pkg::mem_op_t                 in_mem_op,
    input  logic [exe_pkg::XLEN-1:0]         in_store_data,
    input  logic [exe_pkg::REG_ADDR_W-1:0]   in_dest,
    input  logic                             out_allowin,
    output logic                             out_valid,
    output logic [exe_pkg::XLEN-1:0]         out_pc,
    output logic [exe_pkg::XLEN-1:0]         out_result,
    output logic [exe_pkg::REG_ADDR_W-1:0]   out_dest,
    output logic                             out_ex,
    output exe_pkg::ecode_t                  out_ecode,
    output logic [exe_pkg::XLEN-1:0]         out_bad_addr,
    input  logic                             flush,
    output logic                             data_sram_req,
    output logic                             data_sram_wr,
    output logic [1:0]                       data_sram_size,
    output logic [3:0]                       data_sram_we,
    output logic [exe_pkg::XLEN-1:0]         data_sram_addr,
    output logic [exe_pkg::XLEN-1:0]         data_sram_wdata,
    input  logic                             data_sram_addr_ok,
    input  logic [31:0]                      csr_crmd,
    input  logic [31:0]                      csr_asid,
    input  logic [31:0]                      csr_dmw0,
    input  logic [31:0]                      csr_dmw1,
    tlb_search_if.exe                        srch
);

    logic                           es_valid;
    exe_pkg::alu_op_t               es_alu_op;
    exe_pkg::mem_op_t               es_mem_op;
    logic [exe_pkg::XLEN-1:0]       es_src1;
    logic [exe_pkg::XLEN-1:0]       es_src2;
    logic [exe_pkg::XLEN-1:0]       es_store_data;
    logic [exe_pkg::XLEN-1:0]       ea;
    logic                           is_load;
    logic                           is_store;
    logic                           is_mem;
    logic                           misaligned;
    logic                           ade;
    exe_pkg::ecode_t                fault;
    logic                           ex;
    logic                           ready_go;

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            out_pc        <= in_pc;
            es_alu_op     <= in_alu_op;
            es_src1       <= in_src1;
            es_src2       <= in_src2;
            es_mem_op     <= in_mem_op;
            es_store_data <= in_store_data;
            out_dest      <= in_dest;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush)
            es_valid <= 1'b0;
        else if (in_allowin)
            es_valid <= in_valid;
    end

    assign ea = es_src1 + es_src2;

    alu u_alu (
        .op     (es_alu_op),
        .src1   (es_src1),
        .src2   (es_src2),
        .result (out_result)
    );

    mem_request u_mem_request (
        .mem_op     (es_mem_op),
        .addr       (ea),
        .store_data (es_store_data),
        .is_load    (is_load),
        .is_store   (is_store),
        .misaligned (misaligned),
        .size       (data_sram_size),
        .strobe     (data_sram_we),
        .wdata      (data_sram_wdata)
    );

    addr_translate u_addr_translate (
        .vaddr    (ea),
        .is_load  (is_load),
        .is_store (is_store),
        .csr_crmd (csr_crmd),
        .csr_asid (csr_asid),
        .csr_dmw0 (csr_dmw0),
        .csr_dmw1 (csr_dmw1),
        .srch     (srch),
        .paddr    (data_sram_addr),
        .fault    (fault),
        .ade      (ade)
    );

    assign is_mem = is_load | is_store;
    assign ex     = is_mem & (ade | misaligned | (fault != exe_pkg::ecode_none));

    // fixed priority, ade over ale over translation fault
    assign out_ecode    = ade        ? exe_pkg::ecode_ade
                        : misaligned ? exe_pkg::ecode_ale
                        : fault;
    assign out_ex       = es_valid & ex;
    assign out_bad_addr = ea;

    assign data_sram_wr  = is_store;
    assign data_sram_req = es_valid & is_mem & ~ex & out_allowin & ~flush;

    // good memory items wait for addr_ok, everything else goes next cycle
    assign ready_go   = (is_mem && !ex) ? (data_sram_req & data_sram_addr_ok) : 1'b1;
    assign out_valid  = es_valid & ready_go & ~flush;
    assign in_allowin = ~es_valid | (ready_go & out_allowin);

endmodule

//--- hw/tlb.sv
`timescale 1ns/1ps

module tlb #(
    parameter int tlb_entries = 16
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wr_en,
    input  logic [$clog2(tlb_entries)-1:0]  wr_index,
    input  mmu_pkg::tlb_entry_t             wr_entry,
    tlb_search_if.tlb                       srch
);

    localparam int idx_w = $clog2(tlb_entries);

    mmu_pkg::tlb_entry_t        entries [tlb_entries];
    logic [tlb_entries-1:0]     match;
    logic [idx_w-1:0]           hit_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_entries; i++)
                entries[i].e <= 1'b0;   // only the exist bit matters
        end else if (wr_en) begin
            entries[wr_index] <= wr_entry;
        end
    end

    // vppn holds va[31:13], a 4M page skips the low ten bits
    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            match[i] = entries[i].e
                     & (entries[i].g | (entries[i].asid == srch.asid))
                     & (entries[i].vppn[18:10] == srch.va_high[19:11])
                     & ((entries[i].ps == mmu_pkg::PS_4M)
                        | (entries[i].vppn[9:0] == srch.va_high[10:1]));
        end
    end

    always_comb begin
        hit_idx = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (match[i])
                hit_idx = idx_w'(i);    // lowest index wins
        end
    end

    assign srch.found = |match;
    assign srch.index = hit_idx;
    assign srch.ppn   = entries[hit_idx].ppn;
    assign srch.ps    = entries[hit_idx].ps;
    assign srch.plv   = entries[hit_idx].plv;
    assign srch.mat   = entries[hit_idx].mat;
    assign srch.d     = entries[hit_idx].d;
    assign srch.v     = entries[hit_idx].v;

endmodule

//--- hw/exe_top.sv
`timescale 1ns/1ps

module exe_top #(
    parameter int tlb_entries = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             in_valid,
    output logic                             in_allowin,
    input  logic [exe_pkg::XLEN-1:0]         in_pc,
    input  exe_pkg::alu_op_t                 in_alu_op,
    input  logic [exe_pkg::XLEN-1:0]         in_src1,
    input  logic [exe_pkg::XLEN-1:0]         in_src2,
    input  exe_pkg::mem_op_t                 in_mem_op,
    input  logic [exe_pkg::XLEN-1:0]         in_store_data,
    input  logic [exe_pkg::REG_ADDR_W-1:0]   in_dest,
    input  logic                             out_allowin,
    output logic                             out_valid,
    output logic [exe_pkg::XLEN-1:0]         out_pc,
    output logic [exe_pkg::XLEN-1:0]         out_result,
    output logic [exe_pkg::REG_ADDR_W-1:0]   out_dest,
    output logic                             out_ex,
    output exe_pkg::ecode_t                  out_ecode,
    output logic [exe_pkg::XLEN-1:0]         out_bad_addr,
    input  logic                             flush,
    output logic                             data_sram_req,
    output logic                             data_sram_wr,
    output logic [1:0]                       data_sram_size,
    output logic [3:0]                       data_sram_we,
    output logic [exe_pkg::XLEN-1:0]         data_sram_addr,
    output logic [exe_pkg::XLEN-1:0]         data_sram_wdata,
    input  logic                             data_sram_addr_ok,
    input  logic [31:0]                      csr_crmd,
    input  logic [31:0]                      csr_asid,
    input  logic [31:0]                      csr_dmw0,
    input  logic [31:0]                      csr_dmw1,
    input  logic                             tlbwr_en,
    input  logic [$clog2(tlb_entries)-1:0]   tlbwr_index,
    input  mmu_pkg::tlb_entry_t              tlbwr_entry
);

    tlb_search_if #(.tlb_entries(tlb_entries)) srch_if ();

    // stage ports share their names with the top level
    exe_stage u_exe_stage (
        .srch (srch_if.exe),
        .*
    );

    tlb #(
        .tlb_entries (tlb_entries)
    ) u_tlb (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (tlbwr_en),
        .wr_index (tlbwr_index),
        .wr_entry (tlbwr_entry),
        .srch     (srch_if.tlb)
    );

endmodule

//--- tests/exe_tb.sv
`timescale 1ns/1ps

module exe_tb;

    logic clk;
    logic reset;
    logic in_valid, in_allowin, out_allowin, out_valid, out_ex, flush;
    logic [31:0] in_pc, in_src1, in_src2, in_store_data;
    exe_pkg::alu_op_t in_alu_op;
    exe_pkg::mem_op_t in_mem_op;
    logic [4:0] in_dest, out_dest;
    logic [31:0] out_pc, out_result, out_bad_addr;
    exe_pkg::ecode_t out_ecode;
    logic data_sram_req, data_sram_wr, data_sram_addr_ok;
    logic [1:0] data_sram_size;
    logic [3:0] data_sram_we;
    logic [31:0] data_sram_addr, data_sram_wdata;
    logic [31:0] csr_crmd, csr_asid, csr_dmw0, csr_dmw1;
    logic tlbwr_en;
    logic [3:0] tlbwr_index;
    mmu_pkg::tlb_entry_t tlbwr_entry;

    mmu_pkg::tlb_entry_t tlb_ref [16];   // what the tb has written so far
    int errors, test_err, tests_run, ok_cnt;
    int req_seen, out_seen;
    logic [31:0] cap_result, cap_bad, cap_pc, r_addr, r_wdata;
    logic [5:0] cap_ecode;
    logic [4:0] cap_dest;
    logic cap_ex, r_wr;
    logic [1:0] r_size;
    logic [3:0] r_we;
    logic [31:0] exp_result, exp_addr, exp_wdata, exp_pc, exp_ea;
    logic [5:0] exp_ecode;
    logic [4:0] exp_dest;
    logic [3:0] exp_we;
    logic [1:0] exp_size;
    logic exp_ex, exp_req, exp_st;

    exe_top u_exe_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // addr_ok pulses every 1 to 4 cycles, independent of req
    always @(posedge clk) begin
        #2;
        if (ok_cnt == 0) begin
            data_sram_addr_ok = 1'b1;
            ok_cnt = int'($urandom % 4);
        end else begin
            data_sram_addr_ok = 1'b0;
            ok_cnt--;
        end
    end

    always @(negedge clk) begin
        if (data_sram_req && data_sram_addr_ok) begin
            req_seen++;
            r_addr  = data_sram_addr;
            r_size  = data_sram_size;
            r_we    = data_sram_we;
            r_wdata = data_sram_wdata;
            r_wr    = data_sram_wr;
        end
        if (out_valid && out_allowin) begin
            out_seen++;
            cap_result = out_result;
            cap_ex     = out_ex;
            cap_ecode  = 6'(out_ecode);
            cap_bad    = out_bad_addr;
            cap_pc     = out_pc;
            cap_dest   = out_dest;
        end
    end

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors++;
            test_err++;
        end
    endtask

    task automatic stall(string what);
        $display("timeout waiting for %s", what);
        $display(">>> FAIL");
        $finish;
    endtask

    function automatic logic [31:0] alu_ref(int op, logic [31:0] a, logic [31:0] b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return {31'b0, $signed(a) < $signed(b)};
            3: return {31'b0, a < b};
            4: return a & b;
            5: return a | b;
            6: return a ^ b;
            7: return ~(a | b);
            8: return a << b[4:0];
            9: return a >> b[4:0];
            10: return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
            default: return b;
        endcase
    endfunction

    // direct, window, then tlb lookup; fault 0 means none
    task automatic translate(input logic [31:0] va, input logic ld, input logic st,
                             output logic [31:0] pa, output logic [5:0] fault,
                             output logic ade);
        logic [1:0] plv;
        int hit;
        plv   = csr_crmd[1:0];
        fault = 6'h00;
        ade   = 1'b0;
        hit   = -1;
        pa    = va;
        if (csr_crmd[3] && !csr_crmd[4])
            return;
        if (csr_dmw0[plv] && csr_dmw0[31:29] == va[31:29]) begin
            pa = {csr_dmw0[27:25], va[28:0]};
            return;
        end
        if (csr_dmw1[plv] && csr_dmw1[31:29] == va[31:29]) begin
            pa = {csr_dmw1[27:25], va[28:0]};
            return;
        end
        ade = va[31] && plv == 2'd3;
        for (int i = 15; i >= 0; i--) begin
            if (tlb_ref[i].e && (tlb_ref[i].g || tlb_ref[i].asid == csr_asid[9:0])
                && (tlb_ref[i].ps == 6'd22 ? tlb_ref[i].vppn[18:10] == va[31:23]
                                           : tlb_ref[i].vppn == va[31:13]))
                hit = i;
        end
        if (hit < 0) begin
            fault = 6'h3f;
            return;
        end
        pa = (tlb_ref[hit].ps == 6'd22) ? {tlb_ref[hit].ppn[19:10], va[21:0]}
                                         : {tlb_ref[hit].ppn, va[11:0]};
        if (ld && !tlb_ref[hit].v)
            fault = 6'h01;
        else if (st && !tlb_ref[hit].v)
            fault = 6'h02;
        else if (plv > tlb_ref[hit].plv)
            fault = 6'h07;
        else if (st && !tlb_ref[hit].d)
            fault = 6'h04;
    endtask

    task automatic predict(int op, logic [31:0] s1, logic [31:0] s2, int mop,
                           logic [31:0] sd);
        logic ld, mis, ade;
        logic [5:0] fault;
        ld       = mop >= 1 && mop <= 5;
        exp_st   = mop >= 6 && mop <= 8;
        exp_ea   = s1 + s2;
        exp_size = (mop inside {1, 2, 6}) ? 2'd0 : (mop inside {3, 4, 7}) ? 2'd1 : 2'd2;
        mis      = (exp_size == 2'd1 && exp_ea[0]) || (exp_size == 2'd2 && exp_ea[1:0] != 0);
        exp_we   = !exp_st ? 4'b0000 : exp_size == 2'd0 ? 4'b0001 << exp_ea[1:0]
                 : exp_size == 2'd1 ? (exp_ea[1] ? 4'b1100 : 4'b0011) : 4'b1111;
        exp_wdata = exp_size == 2'd0 ? {4{sd[7:0]}} : exp_size == 2'd1 ? {2{sd[15:0]}} : sd;
        translate(exp_ea, ld, exp_st, exp_addr, fault, ade);
        exp_result = alu_ref(op, s1, s2);
        exp_ex     = (ld || exp_st) && (ade || mis || fault != 0);
        exp_ecode  = !(ld || exp_st) ? 6'h00 : ade ? 6'h08 : mis ? 6'h09 : fault;
        exp_req    = (ld || exp_st) && !exp_ex;
    endtask

    // called 2 ns after an edge with the stage empty
    task automatic run_item(string name, int op, logic [31:0] s1, logic [31:0] s2,
                            int mop, logic [31:0] sd, logic bp);
        int t;
        predict(op, s1, s2, mop, sd);
        exp_pc        = $urandom;
        exp_dest      = 5'($urandom);
        req_seen      = 0;
        out_seen      = 0;
        in_valid      = 1'b1;
        in_alu_op     = exe_pkg::alu_op_t'(op[3:0]);
        in_mem_op     = exe_pkg::mem_op_t'(mop[3:0]);
        in_src1       = s1;
        in_src2       = s2;
        in_store_data = sd;
        in_pc         = exp_pc;
        in_dest       = exp_dest;
        t = 0;
        @(negedge clk);
        while (!in_allowin) begin
            if (++t > 50)
                stall("in_allowin");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        t = 0;
        while (out_seen == 0) begin
            if (bp)
                out_allowin = 1'($urandom % 2);
            if (++t > 60)
                stall("out_valid");
            @(posedge clk);
            #2;
        end
        out_allowin = 1'b1;
        check({name, " result"}, exp_result, cap_result);
        check({name, " pc"}, exp_pc, cap_pc);
        check({name, " dest"}, 32'(exp_dest), 32'(cap_dest));
        check({name, " ex"}, 32'(exp_ex), 32'(cap_ex));
        check({name, " ecode"}, 32'(exp_ecode), 32'(cap_ecode));
        check({name, " requests"}, 32'(exp_req), 32'(req_seen));
        if (exp_ex)
            check({name, " bad_addr"}, exp_ea, cap_bad);
        if (exp_req && req_seen == 1) begin
            check({name, " addr"}, exp_addr, r_addr);
            check({name, " size"}, 32'(exp_size), 32'(r_size));
            check({name, " strobe"}, 32'(exp_we), 32'(r_we));
            check({name, " wr"}, 32'(exp_st), 32'(r_wr));
            if (exp_st)
                check({name, " wdata"}, exp_wdata, r_wdata);
        end
    endtask

    task automatic tlb_write(int idx, logic [18:0] vppn, logic [5:0] ps, logic g,
                             logic [19:0] ppn, logic [1:0] plv, logic d, logic v);
        mmu_pkg::tlb_entry_t ent;
        ent = '{vppn: vppn, ps: ps, g: g, asid: 10'd5, ppn: ppn, plv: plv,
                mat: 2'd1, d: d, v: v, e: 1'b1};
        tlb_ref[idx] = ent;
        tlbwr_en     = 1'b1;
        tlbwr_index  = 4'(idx);
        tlbwr_entry  = ent;
        @(posedge clk);
        #2;
        tlbwr_en = 1'b0;
    endtask

    task automatic report(string name);
        tests_run++;
        $display("test %0d %s done, %0d errors", tests_run, name, test_err);
        test_err = 0;
    endtask

    initial begin
        logic [31:0] snap_res;
        logic [31:0] tlb_va [7];
        int mops [8];
        void'($urandom(32'hf39c30d9));
        mops = '{1, 2, 3, 4, 5, 6, 7, 8};
        // one address per written entry, then one that misses
        tlb_va = '{32'h0040_0000, 32'h0812_3000, 32'h0100_0000, 32'h0200_0000,
                   32'h0300_0000, 32'h0400_0000, 32'h0500_0000};
        {in_valid, flush, tlbwr_en, data_sram_addr_ok} = '0;
        {in_pc, in_src1, in_src2, in_store_data, in_dest, tlbwr_index} = '0;
        in_alu_op   = exe_pkg::alu_add;
        in_mem_op   = exe_pkg::mem_none;
        tlbwr_entry = '0;
        out_allowin = 1'b1;
        csr_crmd    = 32'h8;      // direct mode, level 0
        csr_asid    = 32'd5;
        csr_dmw0    = 32'h0;
        csr_dmw1    = 32'h0;
        for (int i = 0; i < 16; i++)
            tlb_ref[i] = '0;
        {errors, test_err, tests_run, ok_cnt, req_seen, out_seen} = '0;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int i = 0; i < 40; i++)
            run_item("alu", i % 12, $urandom, $urandom, 0, 32'h0, 1'b0);
        report("alu");

        for (int off = 0; off < 4; off++)
            foreach (mops[k])
                if (!((mops[k] inside {3, 4, 7} && off[0]) || (mops[k] inside {5, 8} && off != 0)))
                    run_item("direct", 0, $urandom & 32'hfffffffc, 32'(off), mops[k],
                             $urandom, 1'b0);
        report("direct");

        run_item("ale", 0, 32'h100, 32'h1, 3, 32'h0, 1'b0);
        run_item("ale", 0, 32'h100, 32'h3, 7, 32'h5a5a, 1'b0);
        run_item("ale", 0, 32'h100, 32'h2, 5, 32'h0, 1'b0);
        run_item("ale", 0, 32'h100, 32'h1, 8, 32'h1234, 1'b0);
        report("misaligned");

        csr_crmd = 32'h10;        // paged, level 0
        csr_dmw0 = 32'ha000_0001;
        csr_dmw1 = 32'h8200_0009;
        run_item("window", 0, 32'ha000_1230, 32'h4, 5, 32'h0, 1'b0);
        run_item("window", 0, 32'h8000_0010, 32'h0, 8, 32'hcafe, 1'b0);
        csr_crmd = 32'h13;
        run_item("window", 0, 32'h8000_0040, 32'h0, 5, 32'h0, 1'b0);
        run_item("window", 0, 32'hc000_0000, 32'h8, 5, 32'h0, 1'b0);
        run_item("window", 0, 32'ha000_0000, 32'h8, 6, 32'h77, 1'b0);
        report("window");

        csr_dmw0 = 32'h0;
        csr_dmw1 = 32'h0;
        tlb_write(0, 19'h00200, 6'd12, 1'b0, 20'h12345, 2'd3, 1'b1, 1'b1);
        tlb_write(1, 19'h04000, 6'd22, 1'b0, 20'habc00, 2'd3, 1'b1, 1'b1);
        tlb_write(2, 19'h00800, 6'd12, 1'b0, 20'h00111, 2'd3, 1'b1, 1'b0);
        tlb_write(3, 19'h01000, 6'd12, 1'b0, 20'h00222, 2'd3, 1'b0, 1'b1);
        tlb_write(4, 19'h01800, 6'd12, 1'b1, 20'h00333, 2'd3, 1'b1, 1'b1);
        tlb_write(5, 19'h02000, 6'd12, 1'b1, 20'h00444, 2'd0, 1'b1, 1'b1);
        for (int p = 0; p < 2; p++) begin
            csr_crmd = p == 0 ? 32'h10 : 32'h13;
            csr_asid = p == 0 ? 32'd5 : 32'd9;
            for (int a = 0; a < 7; a++) begin
                run_item("tlb", 0, tlb_va[a], 32'h124, 5, 32'h0, 1'b0);
                run_item("tlb", 0, tlb_va[a], 32'h3f8, 8, $urandom, 1'b0);
            end
        end
        report("tlb");

        csr_crmd = 32'h8;
        for (int i = 0; i < 8; i++)
            run_item("backpressure", i % 12, $urandom & 32'hfffffffc, 32'(i % 4),
                     mops[i], $urandom, 1'b1);
        out_allowin = 1'b0;
        in_valid    = 1'b1;
        in_alu_op   = exe_pkg::alu_xor;
        in_mem_op   = exe_pkg::mem_none;
        in_src1     = 32'h1234_5678;
        in_src2     = 32'hffff_0000;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        snap_res = alu_ref(6, 32'h1234_5678, 32'hffff_0000);
        repeat (6) begin
            @(negedge clk);
            check("hold valid", 32'd1, 32'(out_valid));
            check("hold result", snap_res, out_result);
        end
        @(posedge clk);
        #2;
        out_seen = 0;
        flush    = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        check("flush allowin", 32'd1, 32'(in_allowin));
        out_allowin = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        check("flush output", 32'd0, 32'(out_seen));
        report("backpressure");

        $display("%0d tests, %0d failed checks", tests_run, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- exe_sub.f
common/exe_pkg.sv
common/mmu_pkg.sv
common/tlb_search_if.sv
exe/alu.sv
exe/mem_request.sv
exe/addr_translate.sv
exe/exe_stage.sv
hw/tlb.sv
hw/exe_top.sv
tests/exe_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f exe_sub.f --top-module exe_tb -o exe_tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/exe_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q ">>> PASS"; then
    exit 0
fi
exit 1
